// ==== Bender.yml ====
package:
  name: mips_system

sources:
  - hw/avalon_pkg.sv
  - hw/mips_pkg.sv
  - hw/mips_alu.sv
  - hw/mips_regfile.sv
  - hw/mips_cpu.sv
  - hw/avalon_ram.sv
  - hw/mips_system.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/mips_system_tb.sv

// ==== hw/avalon_pkg.sv ====
package avalon_pkg;

    typedef logic [31:0] av_addr_t;  // byte address
    typedef logic [31:0] av_data_t;
    typedef logic [3:0]  av_be_t;    // one bit per byte lane

    localparam int ram_words = 64;

    typedef logic [$clog2(ram_words)-1:0] ram_index_t;  // word index into the RAM

    // master side, held steady while waitrequest is high
    typedef struct packed {
        av_addr_t address;
        logic     read;
        logic     write;
        av_data_t writedata;
        av_be_t   byteenable;
    } av_req_t;

    typedef struct packed {
        av_data_t readdata;     // valid in the cycle waitrequest is low
        logic     waitrequest;
    } av_rsp_t;

endpackage

// ==== hw/avalon_ram.sv ====
`timescale 1ns/1ns

module avalon_ram (
    input  logic                   clk,
    input  logic                   rst_n,
    input  avalon_pkg::av_req_t    bus_req,
    input  logic                   load_en,
    input  avalon_pkg::ram_index_t load_addr,
    input  avalon_pkg::av_data_t   load_data,
    output avalon_pkg::av_rsp_t    bus_rsp
);

    avalon_pkg::av_data_t   mem [avalon_pkg::ram_words];
    avalon_pkg::av_data_t   rd_word;
    avalon_pkg::ram_index_t word_idx;

    logic access;
    logic wait_done;  // wait cycle of the current access has passed
    logic complete;

    assign word_idx = bus_req.address[7:2];  // word address, low bits ignored
    assign access   = bus_req.read || bus_req.write;
    assign complete = access && wait_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_done <= 1'b0;
        end else if (complete) begin
            wait_done <= 1'b0;  // ready for the next access
        end else if (access) begin
            wait_done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (complete && bus_req.write) begin
            for (int b = 0; b < 4; b++) begin
                if (bus_req.byteenable[b]) begin
                    mem[word_idx][8*b +: 8] <= bus_req.writedata[8*b +: 8];
                end
            end
        end
        if (load_en) begin
            mem[load_addr] <= load_data;  // program load, independent of the bus
        end
        rd_word <= mem[word_idx];  // captured during the wait cycle
    end

    assign bus_rsp.waitrequest = access && !wait_done;
    assign bus_rsp.readdata    = rd_word;

endmodule

// ==== hw/mips_alu.sv ====
`timescale 1ns/1ns

module mips_alu (
    input  avalon_pkg::av_data_t a,
    input  avalon_pkg::av_data_t b,
    input  mips_pkg::alu_op_e    op,
    output avalon_pkg::av_data_t result,
    output logic                 equal
);

    avalon_pkg::av_data_t sum;
    avalon_pkg::av_data_t diff;

    assign sum  = a + b;  // wraps modulo 2^32
    assign diff = a - b;

    always_comb begin
        case (op)
            mips_pkg::alu_sub: result = diff;
            default:           result = sum;  // arithmetic and address calc
        endcase
    end

    assign equal = (a == b);  // branch compare for beq

endmodule

// ==== hw/mips_cpu.sv ====
`timescale 1ns/1ns

module mips_cpu (
    input  logic                 clk,
    input  logic                 rst_n,
    input  avalon_pkg::av_rsp_t  bus_rsp,
    output avalon_pkg::av_req_t  bus_req,
    output logic                 active,
    output avalon_pkg::av_data_t register_v0
);

    typedef enum logic [2:0] {
        st_idle,       // held here by reset
        st_fetch,
        st_exec,
        st_mem,
        st_writeback,
        st_halted
    } state_e;

    state_e               state;
    avalon_pkg::av_addr_t pc;          // already advanced past the current instruction
    avalon_pkg::av_data_t ir;
    avalon_pkg::av_data_t alu_out;
    avalon_pkg::av_data_t mem_rdata;

    mips_pkg::instr_r_t   ir_r;
    mips_pkg::instr_i_t   ir_i;
    avalon_pkg::av_data_t imm_sext;
    avalon_pkg::av_addr_t branch_target;

    logic is_rtype;
    logic is_addu;
    logic is_subu;
    logic is_jr;
    logic is_addiu;
    logic is_beq;
    logic is_lw;
    logic is_sw;
    logic is_sb;
    logic is_mem;

    avalon_pkg::av_data_t rs_data;
    avalon_pkg::av_data_t rt_data;
    avalon_pkg::av_data_t alu_b;
    avalon_pkg::av_data_t alu_result;
    mips_pkg::alu_op_e    alu_op;
    logic                 alu_equal;

    logic                 wr_en;
    mips_pkg::reg_idx_t   wr_idx;
    avalon_pkg::av_data_t wr_data;

    assign ir_r = mips_pkg::instr_r_t'(ir);
    assign ir_i = mips_pkg::instr_i_t'(ir);

    assign imm_sext      = {{16{ir_i.imm[15]}}, ir_i.imm};
    assign branch_target = pc + {imm_sext[29:0], 2'b00};  // offset in words

    assign is_rtype = (ir_r.opcode == mips_pkg::op_special);
    assign is_addu  = is_rtype && (ir_r.funct == mips_pkg::fn_addu);
    assign is_subu  = is_rtype && (ir_r.funct == mips_pkg::fn_subu);
    assign is_jr    = is_rtype && (ir_r.funct == mips_pkg::fn_jr);
    assign is_addiu = (ir_i.opcode == mips_pkg::op_addiu);
    assign is_beq   = (ir_i.opcode == mips_pkg::op_beq);
    assign is_lw    = (ir_i.opcode == mips_pkg::op_lw);
    assign is_sw    = (ir_i.opcode == mips_pkg::op_sw);
    assign is_sb    = (ir_i.opcode == mips_pkg::op_sb);
    assign is_mem   = is_lw || is_sw || is_sb;

    // beq compares rs with rt, the rest of the i-types add the immediate
    assign alu_b  = (is_rtype || is_beq) ? rt_data : imm_sext;
    assign alu_op = is_subu ? mips_pkg::alu_sub : mips_pkg::alu_add;

    assign wr_en   = (state == st_writeback);
    assign wr_idx  = is_rtype ? ir_r.rd : ir_i.rt;
    assign wr_data = is_lw ? mem_rdata : alu_out;

    assign active = (state != st_idle) && (state != st_halted);

    mips_regfile i_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs      (ir_i.rs),
        .rt      (ir_i.rt),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .v0      (register_v0)
    );

    mips_alu i_alu (
        .a      (rs_data),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result),
        .equal  (alu_equal)
    );

    // bus request follows the state, operands are stable while stalled
    always_comb begin
        bus_req = '0;
        case (state)
            st_fetch: begin
                bus_req.address    = pc;
                bus_req.read       = 1'b1;
                bus_req.byteenable = 4'b1111;
            end
            st_mem: begin
                bus_req.address = alu_out;
                bus_req.read    = is_lw;
                bus_req.write   = is_sw || is_sb;
                if (is_sb) begin
                    bus_req.writedata  = {4{rt_data[7:0]}};                       // byte on every lane
                    bus_req.byteenable = avalon_pkg::av_be_t'(4'b0001 << alu_out[1:0]);
                end else begin
                    bus_req.writedata  = rt_data;
                    bus_req.byteenable = 4'b1111;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            pc    <= mips_pkg::reset_pc;
        end else begin
            case (state)
                st_idle: state <= st_fetch;
                st_fetch: begin
                    if (!bus_rsp.waitrequest) begin
                        pc    <= pc + 32'd4;
                        state <= st_exec;
                    end
                end
                st_exec: begin
                    if (is_jr) begin
                        if (ir_i.rs == mips_pkg::reg_zero) begin
                            state <= st_halted;  // jr $0 is the halt
                        end else begin
                            pc    <= rs_data;
                            state <= st_fetch;
                        end
                    end else if (is_beq) begin
                        if (alu_equal) begin
                            pc <= branch_target;
                        end
                        state <= st_fetch;
                    end else if (is_mem) begin
                        state <= st_mem;
                    end else if (is_addiu || is_addu || is_subu) begin
                        state <= st_writeback;
                    end else begin
                        state <= st_fetch;  // unsupported opcode runs as a nop
                    end
                end
                st_mem: begin
                    if (!bus_rsp.waitrequest) begin
                        state <= is_lw ? st_writeback : st_fetch;
                    end
                end
                st_writeback: state <= st_fetch;
                default:      state <= st_halted;  // stays until next reset
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == st_fetch) && !bus_rsp.waitrequest) begin
            ir <= bus_rsp.readdata;
        end
        if (state == st_exec) begin
            alu_out <= alu_result;
        end
        if ((state == st_mem) && !bus_rsp.waitrequest) begin
            mem_rdata <= bus_rsp.readdata;
        end
    end

endmodule

// ==== hw/mips_pkg.sv ====
package mips_pkg;

    localparam int reg_count = 32;

    typedef logic [4:0]  reg_idx_t;
    typedef logic [15:0] imm_t;
    typedef logic [4:0]  shamt_t;

    typedef enum logic [5:0] {
        op_special = 6'h00,  // r-type, decoded by funct
        op_beq     = 6'h04,
        op_addiu   = 6'h09,
        op_lw      = 6'h23,
        op_sb      = 6'h28,
        op_sw      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        fn_jr   = 6'h08,
        fn_addu = 6'h21,
        fn_subu = 6'h23
    } funct_e;

    typedef enum logic {
        alu_add,
        alu_sub
    } alu_op_e;

    // register format view of an instruction word
    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        shamt_t   shamt;
        funct_e   funct;
    } instr_r_t;

    // immediate format view of the same word
    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        imm_t     imm;
    } instr_i_t;

    localparam reg_idx_t reg_zero = 5'd0;
    localparam reg_idx_t reg_v0   = 5'd2;

    localparam avalon_pkg::av_addr_t reset_pc = 32'h0000_0000;

endpackage

// ==== hw/mips_regfile.sv ====
`timescale 1ns/1ns

module mips_regfile (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mips_pkg::reg_idx_t   rs,
    input  mips_pkg::reg_idx_t   rt,
    input  logic                 wr_en,
    input  mips_pkg::reg_idx_t   wr_idx,
    input  avalon_pkg::av_data_t wr_data,
    output avalon_pkg::av_data_t rs_data,
    output avalon_pkg::av_data_t rt_data,
    output avalon_pkg::av_data_t v0
);

    avalon_pkg::av_data_t regs [mips_pkg::reg_count];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < mips_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != mips_pkg::reg_zero)) begin  // $0 stays zero
            regs[wr_idx] <= wr_data;
        end
    end

    assign rs_data = regs[rs];
    assign rt_data = regs[rt];

    assign v0 = regs[mips_pkg::reg_v0];  // exported as register_v0

endmodule

// ==== hw/mips_system.sv ====
`timescale 1ns/1ns

module mips_system (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   load_en,
    input  avalon_pkg::ram_index_t load_addr,
    input  avalon_pkg::av_data_t   load_data,
    output logic                   active,
    output avalon_pkg::av_data_t   register_v0
);

    avalon_pkg::av_req_t bus_req;  // cpu is the only master
    avalon_pkg::av_rsp_t bus_rsp;

    mips_cpu i_cpu (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus_rsp     (bus_rsp),
        .bus_req     (bus_req),
        .active      (active),
        .register_v0 (register_v0)
    );

    avalon_ram i_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_req   (bus_req),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .bus_rsp   (bus_rsp)
    );

endmodule

// ==== mips_system.f ====
+incdir+sim
hw/avalon_pkg.sv
hw/mips_pkg.sv
hw/mips_alu.sv
hw/mips_regfile.sv
hw/mips_cpu.sv
hw/avalon_ram.sv
hw/mips_system.sv
sim/mips_system_tb.sv

// ==== sim/mips_programs.svh ====
`ifndef MIPS_PROGRAMS_SVH
`define MIPS_PROGRAMS_SVH

localparam int max_words = 16;
localparam int num_tests = 11;
localparam int rom_words = 50;

// one test is a slice of prog_rom plus the v0 expected at the halt
typedef struct packed {
    logic [7:0]           start;     // first word in prog_rom
    logic [4:0]           count;     // words loaded from address 0 up
    avalon_pkg::av_data_t expected;
} test_entry_t;

// data word for the memory tests sits at byte address 0x80
avalon_pkg::av_data_t prog_rom [rom_words] = '{
    32'h0000_0008,                                              // jr $0 alone
    32'h2402_ffff, 32'h0000_0008,                               // addiu v0, $0, -1
    32'h2408_ffff, 32'h2409_0002, 32'h0109_1021, 32'h0000_0008, // addu wraps
    32'h2408_0001, 32'h2409_0003, 32'h0109_1023, 32'h0000_0008, // subu wraps
    32'h2408_8765, 32'hac08_0080, 32'h8c02_0080, 32'h0000_0008, // sw then lw
    32'h2408_8765, 32'h2409_005a, 32'hac08_0080, 32'ha009_0080, // sb at +0
    32'h8c02_0080, 32'h0000_0008,
    32'h2408_8765, 32'h2409_005a, 32'hac08_0080, 32'ha009_0081, // sb at +1
    32'h8c02_0080, 32'h0000_0008,
    32'h2408_8765, 32'h2409_005a, 32'hac08_0080, 32'ha009_0082, // sb at +2
    32'h8c02_0080, 32'h0000_0008,
    32'h2408_8765, 32'h2409_005a, 32'hac08_0080, 32'ha009_0083, // sb at +3
    32'h8c02_0080, 32'h0000_0008,
    32'h2402_0001, 32'h1000_0001, 32'h2442_0010, 32'h2442_0100, // beq $0,$0 taken
    32'h0000_0008,
    32'h2402_0001, 32'h2408_0005, 32'h1048_0001, 32'h2442_0010, // beq 1,5 not taken
    32'h2442_0100, 32'h0000_0008
};

test_entry_t tests [num_tests] = '{
    '{8'd0,  5'd1, 32'h0000_0000},
    '{8'd1,  5'd2, 32'hffff_ffff},  // 0xffff sign extended
    '{8'd3,  5'd4, 32'h0000_0001},  // 0xffffffff + 2
    '{8'd7,  5'd4, 32'hffff_fffe},  // 1 - 3
    '{8'd11, 5'd4, 32'hffff_8765},
    '{8'd15, 5'd6, 32'hffff_875a},  // lane 0 replaced
    '{8'd21, 5'd6, 32'hffff_5a65},
    '{8'd27, 5'd6, 32'hff5a_8765},
    '{8'd33, 5'd6, 32'h5aff_8765},  // lane 3 replaced
    '{8'd39, 5'd5, 32'h0000_0101},  // skipped addiu of 0x10
    '{8'd44, 5'd6, 32'h0000_0111}   // every addiu executed
};

string test_names [num_tests] = '{
    "halt only", "addiu negative", "addu wrap", "subu wrap", "sw then lw",
    "sb offset 0", "sb offset 1", "sb offset 2", "sb offset 3",
    "beq taken", "beq not taken"
};

`endif

// ==== sim/mips_system_tb.sv ====
`timescale 1ns/1ns

module mips_system_tb;

    `include "mips_programs.svh"

    localparam int reset_cycles = 10;

    logic                   clk;
    logic                   rst_n;
    logic                   load_en;
    avalon_pkg::ram_index_t load_addr;
    avalon_pkg::av_data_t   load_data;
    logic                   active;
    avalon_pkg::av_data_t   register_v0;

    int   pass_count;
    int   fail_count;
    int   cycle_count;
    int   current_test;
    logic test_ok;      // cleared by any failing check of the running test

    mips_system i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .active      (active),
        .register_v0 (register_v0)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    // reset, load, and worst case of six cycles per instruction
    function automatic int cycle_budget();
        int total;
        total = 0;
        for (int t = 0; t < num_tests; t++) begin
            total += reset_cycles + int'(tests[t].count) + max_words * 6 + 20;
        end
        return total;
    endfunction

    task automatic check_data(input string name, input avalon_pkg::av_data_t actual,
                              input avalon_pkg::av_data_t expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s = 0x%h, expected 0x%h",
                     $time, name, actual, expected);
            test_ok = 1'b0;
        end
    endtask

    task automatic check_level(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s = %b, expected %b", $time, name, actual, expected);
            test_ok = 1'b0;
        end
    endtask

    task automatic run_test(input int t);
        test_entry_t entry;
        entry   = tests[t];
        test_ok = 1'b1;

        @(negedge clk);
        rst_n = 1'b0;
        // program goes in while the cpu sits in reset
        for (int c = 0; (c < reset_cycles) || (c < int'(entry.count)); c++) begin
            if (c < int'(entry.count)) begin
                load_en   = 1'b1;
                load_addr = avalon_pkg::ram_index_t'(c);
                load_data = prog_rom[int'(entry.start) + c];
            end else begin
                load_en = 1'b0;
            end
            @(negedge clk);
        end
        load_en = 1'b0;
        check_level("active", active, 1'b0);
        check_data("register_v0", register_v0, 32'h0000_0000);

        rst_n = 1'b1;
        @(negedge clk);
        check_level("active", active, 1'b1);  // first fetch under way

        while (active === 1'b1) begin
            @(negedge clk);
        end
        check_data("register_v0", register_v0, entry.expected);

        if (test_ok) begin
            pass_count++;
            $display("test %0d (%s) ok, v0 = 0x%h", t, test_names[t], register_v0);
        end else begin
            fail_count++;
            $display("test %0d (%s) FAILED", t, test_names[t]);
        end
    endtask

    initial begin : watchdog
        int limit;
        limit       = cycle_budget();
        cycle_count = 0;
        while (cycle_count < limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("test %0d (%s) hung, active did not fall within %0d cycles",
                 current_test, test_names[current_test], limit);
        $display("sim failed");
        $finish;
    end

    initial begin
        rst_n        = 1'b0;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        pass_count   = 0;
        fail_count   = 0;
        current_test = 0;
        test_ok      = 1'b1;

        for (int t = 0; t < num_tests; t++) begin
            current_test = t;
            run_test(t);
        end

        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
